// File: files.f
+incdir+include
logic/cu_stream_pkg.sv
logic/cu_stream_fifo.sv
logic/cu_stream_credit_counter.sv
logic/cu_stream_cmd_fsm.sv
logic/cu_stream_mem_port.sv
logic/cu_stream_top.sv
verification/cu_stream_mem_model.sv
verification/cu_stream_assertions.sv
verification/cu_stream_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stream command unit testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module cu_stream_tb \
  --Mdir "$BUILD_DIR" \
  -f files.f

"./$BUILD_DIR/Vcu_stream_tb" | tee "$LOG"

if grep -q "Simulation failed" "$LOG"; then
  echo "run_sim: testbench reported failure"
  exit 1
fi
echo "run_sim: no failure reported"

// File: verification/cu_stream_tb.sv
/*
  Testbench for the stream command unit.
  Memory word index is address bits 9:2, so bases plus offsets stay below 1 KB.
  Expected records are computed at send time; valid because commands issue
  in request order and the base only changes while the unit is idle.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cu_stream_defines.svh"

module cu_stream_tb;

  import cu_stream_pkg::*;

  localparam int          CLK_NS     = 4;
  localparam int          BP_COUNT   = 2 * `CU_FIFO_DEPTH + 4;
  localparam int          TOTAL_REQ  = 3 + 2 + 40 + BP_COUNT + 12 + 8;
  localparam int          WDOG_CYC   = TOTAL_REQ * 20 + 1500;
  localparam logic [31:0] SEED       = 32'h1048;

  logic           ap_clk;
  logic           areset_control;
  cu_descriptor_t descriptor_in;
  cu_request_t    request_in;
  logic           request_full;
  cu_response_t   response_out;
  logic           response_ready;
  cu_mem_req_t    mem_req_out;
  cu_mem_resp_t   mem_resp_in;
  logic           done_out;
  logic [2:0]     mem_latency;

  logic [31:0]  rng_state;
  logic [31:0]  lat_state;
  logic [31:0]  cur_base;
  logic         desc_given;
  logic [7:0]   next_tag;
  int           errors;
  int           cmp_errors;
  int           cmd_errors;
  int           test_start;
  int           tests_run;
  int           tests_failed;
  int           resp_seen;
  logic [31:0]  shadow [256];
  cu_response_t exp_q[$];
  cu_mem_req_t  exp_cmd_q[$];

  cu_stream_top dut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .descriptor_in (descriptor_in),
    .request_in    (request_in),
    .request_full  (request_full),
    .response_out  (response_out),
    .response_ready(response_ready),
    .mem_req_out   (mem_req_out),
    .mem_resp_in   (mem_resp_in),
    .done_out      (done_out)
  );

  cu_stream_mem_model u_mem (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .mem_req       (mem_req_out),
    .latency       (mem_latency),
    .mem_resp      (mem_resp_in)
  );

  bind cu_stream_top cu_stream_assertions u_assertions (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .mem_req_out   (mem_req_out),
    .mem_resp_in   (mem_resp_in),
    .response_out  (response_out),
    .req_push      (req_in_reg.valid),
    .req_full      (req_full),
    .resp_push     (resp_push),
    .resp_full     (resp_full)
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_NS / 2) ap_clk = ~ap_clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Same fill rule as the memory model
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5a, 8'hc3};
  endfunction

  // Applies the request to the shadow memory, returns the expected record
  function automatic cu_response_t predict_response(input cu_request_t req,
                                                    input logic [31:0] base);
    cu_response_t rsp;
    logic [31:0]  addr;
    logic [7:0]   idx;
    addr      = base + req.offset;
    idx       = addr[9:2];
    rsp       = '0;
    rsp.valid = 1'b1;
    rsp.cmd   = req.cmd;
    rsp.tag   = req.tag;
    if (req.cmd == CU_CMD_WRITE) begin
      for (int b = 0; b < 4; b++) begin
        if (req.wstrb[b]) begin
          shadow[idx][8*b +: 8] = req.wdata[8*b +: 8];
        end
      end
    end else begin
      rsp.rdata = shadow[idx];
    end
    return rsp;
  endfunction

  // Command expected at the memory port; reads carry no strobes
  function automatic cu_mem_req_t expect_command(input cu_request_t req,
                                                 input logic [31:0] base);
    cu_mem_req_t c;
    c       = '0;
    c.valid = 1'b1;
    c.we    = (req.cmd == CU_CMD_WRITE);
    c.addr  = base + req.offset;
    c.wdata = req.wdata;
    c.wstrb = c.we ? req.wstrb : 4'h0;
    return c;
  endfunction

  function automatic int total_errors();
    return errors + cmp_errors + cmd_errors;
  endfunction

  // --------------------------------------------------
  // Stimulus tasks, all entered 1 ns after an edge
  // --------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge ap_clk);
      #1;
    end
  endtask

  task automatic send_request(input cu_cmd_e cmd, input logic [31:0] offset,
                              input logic [31:0] wdata, input logic [3:0] wstrb);
    cu_request_t req;
    req.valid  = 1'b1;
    req.cmd    = cmd;
    req.tag    = next_tag;
    req.offset = offset;
    req.wdata  = wdata;
    req.wstrb  = wstrb;
    // Hold off while the unit is full
    while (request_full) begin
      wait_cycles(1);
    end
    request_in = req;
    exp_cmd_q.push_back(expect_command(req, cur_base));
    exp_q.push_back(predict_response(req, cur_base));
    next_tag = next_tag + 8'd1;
    wait_cycles(1);
    request_in.valid = 1'b0;
  endtask

  task automatic send_random(input logic [31:0] region);
    logic [31:0] r;
    logic [31:0] d;
    rng_state = xorshift32(rng_state);
    r         = rng_state;
    rng_state = xorshift32(rng_state);
    d         = rng_state;
    send_request(r[4] ? CU_CMD_WRITE : CU_CMD_READ,
                 region + {26'd0, r[3:0], 2'b00}, d, r[8:5]);
  endtask

  task automatic load_descriptor(input logic [31:0] base);
    descriptor_in.valid     = 1'b1;
    descriptor_in.base_addr = base;
    cur_base                = base;
    desc_given              = 1'b1;
    wait_cycles(1);
    descriptor_in.valid = 1'b0;
  endtask

  // Everything answered, popped and done_out back high
  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (!(exp_q.size() == 0 && exp_cmd_q.size() == 0 && done_out) && n < limit) begin
      wait_cycles(1);
      n++;
    end
    if (!(exp_q.size() == 0 && exp_cmd_q.size() == 0 && done_out)) begin
      $display("timed out after %0d cycles waiting for the unit to go idle", limit);
      errors++;
    end
  endtask

  task automatic begin_test();
    test_start = total_errors();
  endtask

  task automatic report_test(input int num, input string name);
    tests_run++;
    if (total_errors() == test_start) begin
      $display("test %0d %s: passed", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", num, name, total_errors() - test_start);
    end
  endtask

  // --------------------------------------------------
  // Monitors, sampled mid-cycle
  // --------------------------------------------------
  always @(negedge ap_clk) begin : compare_responses
    cu_response_t want;
    // Record is popped at the coming edge
    if (!areset_control && response_out.valid && response_ready) begin
      resp_seen++;
      if (exp_q.size() == 0) begin
        $display("unexpected response at %0t ns with tag %h", $time, response_out.tag);
        cmp_errors++;
      end else begin
        want = exp_q.pop_front();
        if (response_out.cmd != want.cmd || response_out.tag != want.tag ||
            response_out.rdata != want.rdata) begin
          $display("mismatch at %0t ns: response want cmd %0d tag %h rdata %h, got %0d %h %h",
                   $time, want.cmd, want.tag, want.rdata,
                   response_out.cmd, response_out.tag, response_out.rdata);
          cmp_errors++;
        end
      end
    end
  end

  always @(negedge ap_clk) begin : check_commands
    cu_mem_req_t want;
    if (!areset_control && mem_req_out.valid) begin
      // Latency for this command, sampled by the model at the next edge
      lat_state   = xorshift32(lat_state);
      mem_latency = 3'(lat_state % 32'd6) + 3'd1;
      if (!desc_given) begin
        $display("memory command at %0t ns before any descriptor was given", $time);
        cmd_errors++;
      end
      if (exp_cmd_q.size() == 0) begin
        $display("memory command at %0t ns that no request asked for", $time);
        cmd_errors++;
      end else begin
        want = exp_cmd_q.pop_front();
        if (mem_req_out.addr != want.addr || mem_req_out.we != want.we ||
            mem_req_out.wstrb != want.wstrb ||
            (want.we && mem_req_out.wdata != want.wdata)) begin
          $display("mismatch at %0t ns: command want addr %h we %b strb %h, got %h %b %h",
                   $time, want.addr, want.we, want.wstrb,
                   mem_req_out.addr, mem_req_out.we, mem_req_out.wstrb);
          cmd_errors++;
        end
      end
    end
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin : stimulus
    logic seen_full;
    int   n;
    areset_control = 1'b1;
    descriptor_in  = '0;
    request_in     = '0;
    response_ready = 1'b1;
    mem_latency    = 3'd1;
    rng_state      = SEED;
    lat_state      = xorshift32(SEED);
    cur_base       = 32'h100;
    desc_given     = 1'b0;
    next_tag       = 8'h01;
    errors         = 0;
    cmp_errors     = 0;
    cmd_errors     = 0;
    tests_run      = 0;
    tests_failed   = 0;
    resp_seen      = 0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = fill_word(i[7:0]);
    end
    repeat (10) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;

    // Requests wait for a descriptor, base 0x100 applies once it arrives
    begin_test();
    wait_cycles(2);
    if (!done_out) begin
      $display("done_out low after reset with both queues empty");
      errors++;
    end
    send_request(CU_CMD_WRITE, 32'h0, 32'h11223344, 4'hf);
    send_request(CU_CMD_WRITE, 32'h4, 32'h55667788, 4'hf);
    send_request(CU_CMD_READ, 32'h0, 32'h0, 4'hf);
    wait_cycles(20);
    if (done_out) begin
      $display("done_out high while requests wait for a descriptor");
      errors++;
    end
    load_descriptor(32'h100);
    wait_done(200);
    report_test(1, "held until descriptor");

    begin_test();
    send_request(CU_CMD_WRITE, 32'h40, 32'hdeadbeef, 4'b0101);
    send_request(CU_CMD_READ, 32'h40, 32'h0, 4'h0);
    wait_done(200);
    report_test(2, "write then read");

    begin_test();
    for (int i = 0; i < 40; i++) begin
      send_random(32'h0);
    end
    wait_done(800);
    report_test(3, "random ordering");

    // Consumer stalls until the input side reports full
    begin_test();
    response_ready = 1'b0;
    seen_full      = 1'b0;
    fork
      begin
        for (int i = 0; i < BP_COUNT; i++) begin
          send_random(32'h80);
        end
      end
      begin
        n = 0;
        while (!request_full && n < 600) begin
          wait_cycles(1);
          n++;
        end
        seen_full = request_full;
        wait_cycles(8);
        response_ready = 1'b1;
      end
    join
    if (!seen_full) begin
      $display("request_full never rose while responses were held back");
      errors++;
    end
    wait_done(800);
    report_test(4, "back-pressure");

    begin_test();
    load_descriptor(32'h200);
    for (int i = 0; i < 6; i++) begin
      rng_state = xorshift32(rng_state);
      send_request(CU_CMD_WRITE, 32'(i * 4), rng_state, 4'hf);
    end
    for (int i = 0; i < 6; i++) begin
      send_request(CU_CMD_READ, 32'(i * 4), 32'h0, 4'h0);
    end
    wait_done(400);
    report_test(5, "base change");

    begin_test();
    for (int i = 0; i < 3; i++) begin
      send_random(32'h20);
    end
    if (done_out) begin
      $display("done_out high while work is outstanding");
      errors++;
    end
    for (int i = 0; i < 5; i++) begin
      send_random(32'h20);
    end
    wait_done(400);
    if (!done_out) begin
      $display("done_out low after the last response was popped");
      errors++;
    end
    report_test(6, "completion");

    $display("tests run %0d, tests failed %0d, errors %0d, responses checked %0d",
             tests_run, tests_failed, total_errors(), resp_seen);
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin : watchdog
    #(WDOG_CYC * CLK_NS);
    $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/cu_stream_assertions.sv
/*
  Protocol checks bound into the stream command unit top level.
  Assumes one memory command in flight, as the command FSM enforces.
*/
`timescale 1ns/1ps
`default_nettype none

module cu_stream_assertions (
  input logic                        ap_clk,
  input logic                        areset_control,
  input cu_stream_pkg::cu_mem_req_t  mem_req_out,
  input cu_stream_pkg::cu_mem_resp_t mem_resp_in,
  input cu_stream_pkg::cu_response_t response_out,
  input logic                        req_push,
  input logic                        req_full,
  input logic                        resp_push,
  input logic                        resp_full
);

  // Command sent, reply not yet seen
  logic pending;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pending <= 1'b0;
    end else if (mem_req_out.valid) begin
      pending <= 1'b1;
    end else if (mem_resp_in.valid) begin
      pending <= 1'b0;
    end
  end

  // --------------------------------------------------
  // Rules
  // --------------------------------------------------
  no_overlap: assert property (@(posedge ap_clk) disable iff (areset_control)
    mem_req_out.valid |-> !pending)
    else $error("memory command issued while another is pending");

  resp_low_after_reset: assert property (@(posedge ap_clk)
    $fell(areset_control) |-> !response_out.valid)
    else $error("response valid high right after reset");

  // Both queues, push into a full queue
  no_req_overflow: assert property (@(posedge ap_clk) disable iff (areset_control)
    !(req_push && req_full))
    else $error("push into the full request queue");

  no_resp_overflow: assert property (@(posedge ap_clk) disable iff (areset_control)
    !(resp_push && resp_full))
    else $error("push into the full response queue");

endmodule

`default_nettype wire

// File: verification/cu_stream_mem_model.sv
/*
  Behavioral word memory for the testbench, 256 words.
  Only address bits 9:2 pick a word, higher bits wrap around.
  One command at a time; the reply comes latency cycles later, latency 1 to 7.
  Outputs change 1 ns after the rising edge.
*/
`timescale 1ns/1ps
`default_nettype none

module cu_stream_mem_model (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  cu_stream_pkg::cu_mem_req_t  mem_req,
  input  logic [2:0]                  latency,
  output cu_stream_pkg::cu_mem_resp_t mem_resp
);

  import cu_stream_pkg::*;

  logic [31:0] words [256];
  cu_mem_req_t cmd;
  logic        rst;
  logic [2:0]  lat;
  logic [2:0]  count;
  logic [31:0] held_rdata;
  logic [7:0]  idx;

  // Fill pattern uses every bit of the word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      words[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};
    end
    count      = '0;
    held_rdata = '0;
    mem_resp   = '0;
  end

  // --------------------------------------------------
  // Sample at the edge, answer 1 ns later
  // --------------------------------------------------
  always @(posedge ap_clk) begin
    cmd = mem_req;
    rst = areset_control;
    lat = latency;
    #1;
    mem_resp.valid = 1'b0;
    if (rst) begin
      count = '0;
    end else begin
      // Countdown reached, one-cycle reply pulse
      if (count == 3'd1) begin
        mem_resp.valid = 1'b1;
        mem_resp.rdata = held_rdata;
      end
      if (count != '0) begin
        count = count - 3'd1;
      end
      if (cmd.valid) begin
        idx        = cmd.addr[9:2];
        held_rdata = words[idx];
        // Byte merge under the strobes
        if (cmd.we) begin
          for (int b = 0; b < 4; b++) begin
            if (cmd.wstrb[b]) begin
              words[idx][8*b +: 8] = cmd.wdata[8*b +: 8];
            end
          end
        end
        count = lat;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/cu_stream_top.sv
/*
  Stream command unit top level.
  Requests are registered once, queued, issued in order, answered in order.
  No command leaves before a descriptor has been latched.
  request_full counts the input register as well as the queue,
  so a sender that obeys it can never overrun the request queue.
  response_out is straight from the response queue head, unregistered.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cu_stream_defines.svh"

module cu_stream_top (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  cu_stream_pkg::cu_descriptor_t descriptor_in,
  input  cu_stream_pkg::cu_request_t    request_in,
  output logic                         request_full,
  output cu_stream_pkg::cu_response_t   response_out,
  input  logic                         response_ready,
  output cu_stream_pkg::cu_mem_req_t    mem_req_out,
  input  cu_stream_pkg::cu_mem_resp_t   mem_resp_in,
  output logic                         done_out
);

  import cu_stream_pkg::*;

  cu_descriptor_t desc_reg;
  cu_request_t    req_in_reg;
  cu_request_t    req_head;
  cu_response_t   resp_rec;
  cu_response_t   resp_head;

  logic                 req_empty;
  logic                 req_full;
  logic                 req_pop;
  logic                 resp_push;
  logic                 resp_pop;
  logic                 resp_empty;
  logic                 resp_full;
  logic                 issue;
  logic                 fsm_idle;
  logic                 credit_avail;
  logic [`CU_CNT_W-1:0] credit_in_use;
  logic                 req_take;
  logic [`CU_CNT_W-1:0] req_level;
  logic [`CU_CNT_W-1:0] req_level_next;

  // --------------------------------------------------
  // Input registers
  // --------------------------------------------------
  assign req_take = request_in.valid & ~request_full;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_in_reg.valid <= 1'b0;
      desc_reg.valid   <= 1'b0;
    end else begin
      req_in_reg       <= request_in;
      req_in_reg.valid <= req_take;
      // Descriptor holds until replaced
      if (descriptor_in.valid) begin
        desc_reg <= descriptor_in;
      end
    end
  end

  // Requests held in the input register plus the queue
  always_comb begin
    case ({req_take, req_pop})
      2'b10:   req_level_next = req_level + 1'b1;
      2'b01:   req_level_next = req_level - 1'b1;
      default: req_level_next = req_level;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      req_level    <= '0;
      request_full <= 1'b0;
    end else begin
      req_level    <= req_level_next;
      request_full <= req_full | (req_level_next >= `CU_CNT_W'(`CU_FIFO_DEPTH));
    end
  end

  // --------------------------------------------------
  // Request queue and command path
  // --------------------------------------------------
  cu_stream_fifo #(
    .WIDTH($bits(cu_request_t)),
    .DEPTH(`CU_FIFO_DEPTH)
  ) u_req_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push          (req_in_reg.valid),
    .pop           (req_pop),
    .din           (req_in_reg),
    .dout          (req_head),
    .empty         (req_empty),
    .full          (req_full)
  );

  // Credits bound the response queue, one slot per issued command
  cu_stream_cmd_fsm u_cmd_fsm (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .req_head_valid(~req_empty),
    .credit_avail  (credit_avail),
    .desc_valid    (desc_reg.valid),
    .mem_done      (mem_resp_in.valid),
    .req_pop       (req_pop),
    .issue         (issue),
    .idle          (fsm_idle)
  );

  cu_stream_mem_port u_mem_port (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .issue         (issue),
    .head          (req_head),
    .base_addr     (desc_reg.base_addr),
    .mem_resp_in   (mem_resp_in),
    .mem_req_out   (mem_req_out),
    .resp_push     (resp_push),
    .resp_rec      (resp_rec)
  );

  // Slot reserved at issue, freed when the consumer pops
  cu_stream_credit_counter #(
    .LIMIT(`CU_FIFO_DEPTH)
  ) u_credit (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .take          (issue),
    .give          (resp_pop),
    .credit_avail  (credit_avail),
    .in_use        (credit_in_use)
  );

  // --------------------------------------------------
  // Response queue and output
  // --------------------------------------------------
  cu_stream_fifo #(
    .WIDTH($bits(cu_response_t)),
    .DEPTH(`CU_FIFO_DEPTH)
  ) u_resp_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .push          (resp_push),
    .pop           (resp_pop),
    .din           (resp_rec),
    .dout          (resp_head),
    .empty         (resp_empty),
    .full          (resp_full)
  );

  always_comb begin
    response_out       = resp_head;
    response_out.valid = ~resp_empty;
  end

  assign resp_pop = response_out.valid & response_ready;

  // Done when nothing is queued, in flight or unpopped
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      done_out <= 1'b1;
    end else begin
      done_out <= fsm_idle & req_empty & resp_empty & ~req_in_reg.valid &
                  (credit_in_use == '0);
    end
  end

endmodule

`default_nettype wire

// File: logic/cu_stream_mem_port.sv
/*
  Memory command register and response capture.
  The address is base plus offset, sampled on issue.
  Reads go out with zero strobes; write responses carry zero rdata.
  Assumes one command in flight, so one cmd/tag holding register is enough.
*/
`timescale 1ns/1ps
`default_nettype none

`include "cu_stream_defines.svh"

module cu_stream_mem_port (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        issue,
  input  cu_stream_pkg::cu_request_t  head,
  input  logic [`CU_ADDR_W-1:0]       base_addr,
  input  cu_stream_pkg::cu_mem_resp_t mem_resp_in,
  output cu_stream_pkg::cu_mem_req_t  mem_req_out,
  output logic                        resp_push,
  output cu_stream_pkg::cu_response_t resp_rec
);

  import cu_stream_pkg::*;

  // Identity of the command in flight
  cu_cmd_e              pend_cmd;
  logic [`CU_TAG_W-1:0] pend_tag;
  logic                 head_is_write;

  assign head_is_write = (head.cmd == CU_CMD_WRITE);

  // --------------------------------------------------
  // Command side
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      mem_req_out.valid <= 1'b0;
    end else begin
      // One-cycle pulse per issue
      mem_req_out.valid <= issue;
      if (issue) begin
        mem_req_out.we    <= head_is_write;
        mem_req_out.addr  <= base_addr + head.offset;
        mem_req_out.wdata <= head.wdata;
        mem_req_out.wstrb <= head_is_write ? head.wstrb : '0;
        pend_cmd          <= head.cmd;
        pend_tag          <= head.tag;
      end
    end
  end

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      resp_rec.valid <= 1'b0;
    end else begin
      resp_rec.valid <= mem_resp_in.valid;
      if (mem_resp_in.valid) begin
        resp_rec.cmd   <= pend_cmd;
        resp_rec.tag   <= pend_tag;
        // Write data never comes back
        resp_rec.rdata <= (pend_cmd == CU_CMD_WRITE) ? '0 : mem_resp_in.rdata;
      end
    end
  end

  // Push strobe is the record's own valid
  assign resp_push = resp_rec.valid;

endmodule

`default_nettype wire

// File: logic/cu_stream_cmd_fsm.sv
/*
  Command sequencer, one memory command in flight at a time.
  Issue needs a queued request, a free response slot and a latched descriptor.
  req_pop and issue are decoded from the ISSUE state, one cycle wide.
  mem_done is the raw memory reply strobe and is only looked at in PENDING.
*/
`timescale 1ns/1ps
`default_nettype none

module cu_stream_cmd_fsm (
  input  logic ap_clk,
  input  logic areset_control,
  input  logic req_head_valid,
  input  logic credit_avail,
  input  logic desc_valid,
  input  logic mem_done,
  output logic req_pop,
  output logic issue,
  output logic idle
);

  import cu_stream_pkg::*;

  cu_state_e state;
  cu_state_e next_state;
  logic      go;

  // Everything needed to start one command
  assign go = req_head_valid & credit_avail & desc_valid;

  // --------------------------------------------------
  // State register
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state <= CU_ST_RESET;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      CU_ST_RESET: begin
        next_state = CU_ST_READY;
      end
      CU_ST_READY: begin
        // Stall here on no credit or no descriptor
        if (go) begin
          next_state = CU_ST_ISSUE;
        end
      end
      CU_ST_ISSUE: begin
        next_state = CU_ST_PENDING;
      end
      CU_ST_PENDING: begin
        // Latency set by the memory
        if (mem_done) begin
          next_state = CU_ST_READY;
        end
      end
      default: begin
        next_state = CU_ST_RESET;
      end
    endcase
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  // Head leaves the queue as the command is registered
  assign req_pop = (state == CU_ST_ISSUE);
  assign issue   = (state == CU_ST_ISSUE);

  // RESET lasts one cycle and holds no work
  assign idle = (state == CU_ST_READY) | (state == CU_ST_RESET);

endmodule

`default_nettype wire

// File: logic/cu_stream_credit_counter.sv
/*
  Up/down count of reserved slots, capped at LIMIT.
  A take at the limit and a give at zero are ignored.
  Take and give in the same cycle leave the count unchanged.
*/
`timescale 1ns/1ps
`default_nettype none

module cu_stream_credit_counter #(
  parameter  int LIMIT = 16,
  localparam int CNT_W = $clog2(LIMIT + 1)
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             take,
  input  logic             give,
  output logic             credit_avail,
  output logic [CNT_W-1:0] in_use
);

  logic do_take;
  logic do_give;

  // Guard both ends of the range
  assign do_take = take & credit_avail;
  assign do_give = give & (in_use != '0);

  // --------------------------------------------------
  // Slot count
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_use <= '0;
    end else begin
      case ({do_take, do_give})
        2'b10:   in_use <= in_use + 1'b1;
        2'b01:   in_use <= in_use - 1'b1;
        // Both or neither
        default: in_use <= in_use;
      endcase
    end
  end

  // At least one free slot
  assign credit_avail = (in_use < CNT_W'(LIMIT));

endmodule

`default_nettype wire

// File: logic/cu_stream_fifo.sv
/*
  Synchronous FIFO with first-word fall-through.
  Head word is on dout whenever empty is low, a pushed word shows one cycle later.
  Push while full and pop while empty are dropped silently.
  DEPTH must be 2 or more; any value, not only powers of two.
*/
`timescale 1ns/1ps
`default_nettype none

module cu_stream_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16
) (
  input  logic             ap_clk,
  input  logic             areset_control,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, no reset needed
  logic [WIDTH-1:0] mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Qualified strobes
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at DEPTH-1
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Write port
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Fall-through read of the head
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: logic/cu_stream_pkg.sv
/*
  Types shared by the stream command unit and its testbench.
  Record field order is fixed, valid is always the top bit.
  Widths come from the defines header.
*/
`default_nettype none

`include "cu_stream_defines.svh"

package cu_stream_pkg;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  // Command code carried by every request
  typedef enum logic {
    CU_CMD_READ  = 1'b0,
    CU_CMD_WRITE = 1'b1
  } cu_cmd_e;

  // Command FSM states
  typedef enum logic [1:0] {
    CU_ST_RESET   = 2'd0,
    CU_ST_READY   = 2'd1,
    CU_ST_ISSUE   = 2'd2,
    CU_ST_PENDING = 2'd3
  } cu_state_e;

  // --------------------------------------------------
  // Records
  // --------------------------------------------------
  // Base address, latched on valid
  typedef struct packed {
    logic                  valid;
    logic [`CU_ADDR_W-1:0] base_addr;
  } cu_descriptor_t;

  // Request from the sender, offset is relative to the base
  typedef struct packed {
    logic                  valid;
    cu_cmd_e               cmd;
    logic [`CU_TAG_W-1:0]  tag;
    logic [`CU_ADDR_W-1:0] offset;
    logic [`CU_DATA_W-1:0] wdata;
    logic [`CU_STRB_W-1:0] wstrb;
  } cu_request_t;

  // Response record, rdata is zero for writes
  typedef struct packed {
    logic                  valid;
    cu_cmd_e               cmd;
    logic [`CU_TAG_W-1:0]  tag;
    logic [`CU_DATA_W-1:0] rdata;
  } cu_response_t;

  // Single-word memory command
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [`CU_ADDR_W-1:0] addr;
    logic [`CU_DATA_W-1:0] wdata;
    logic [`CU_STRB_W-1:0] wstrb;
  } cu_mem_req_t;

  // Memory reply, one per command
  typedef struct packed {
    logic                  valid;
    logic [`CU_DATA_W-1:0] rdata;
  } cu_mem_resp_t;

endpackage

`default_nettype wire

// File: include/cu_stream_defines.svh
/*
  Shared widths and sizes for the stream command unit.
  Guarded, so it may be included from several files in one compile unit.
  CU_CNT_W must hold the value CU_FIFO_DEPTH itself, not only DEPTH-1.
  The address and data widths size the packed records in the package.
*/
`ifndef CU_STREAM_DEFINES_SVH
`define CU_STREAM_DEFINES_SVH

// --------------------------------------------------
// Memory port widths
// --------------------------------------------------
// Byte address into the word memory
`define CU_ADDR_W 32
// One memory word per command
`define CU_DATA_W 32
// One strobe bit per data byte
`define CU_STRB_W 4

// --------------------------------------------------
// Request bookkeeping
// --------------------------------------------------
// Opaque tag, returned unchanged in the response
`define CU_TAG_W 8
// Entries in each queue, also the credit limit
`define CU_FIFO_DEPTH 16
// Occupancy and credit counts, 0 to CU_FIFO_DEPTH
`define CU_CNT_W 5

`endif
